//--- led_matrix_pkg.sv
`default_nettype none

package led_matrix_pkg;

	// panel geometry
	localparam int segments = 2;
	localparam int rows = 8;
	localparam int columns = 32;
	localparam int bitdepth = 8;

	// one memory word per row and column, both segments side by side
	localparam int pixels_per_frame = rows * columns;
	localparam int word_bits = segments * 3 * bitdepth;

	localparam int row_w = $clog2(rows);
	localparam int col_w = $clog2(columns);

	// lit cycles of plane 0, plane b gets display_unit << b
	localparam int display_unit = 4;

	// longest lit period minus one must fit the counter
	localparam int lit_w = $clog2(display_unit << (bitdepth - 1));

	// extra blank cycles when the scan moves to the next row
	localparam int row_turn_cycles = 2;

	// sysclk cycles from one frame_complete pulse to the next
	localparam int frame_cycles = rows * (bitdepth * (2 * columns + 2)
		+ display_unit * ((1 << bitdepth) - 1) + row_turn_cycles);

	typedef logic [row_w-1:0] row_t;
	typedef logic [col_w-1:0] col_t;
	typedef logic [2:0] plane_t;
	typedef logic [lit_w-1:0] lit_t;

	// segment 0 in the upper half, each segment as r g b, msb first
	typedef logic [word_bits-1:0] pixel_word_t;

endpackage

`default_nettype wire

//--- panel_bus_pkg.sv
`default_nettype none

package panel_bus_pkg;

	// write port into the back bank of the frame buffer
	typedef struct packed {
		logic wen;
		led_matrix_pkg::row_t wrow;
		led_matrix_pkg::col_t wcol;
		led_matrix_pkg::pixel_word_t wdata;
	} fb_write_t;

	// signals towards the hub75 connector
	typedef struct packed {
		// r0 g0 b0 r1 g1 b1
		logic [led_matrix_pkg::segments*3-1:0] rgb;
		led_matrix_pkg::row_t a;
		logic lat;
		logic oclk;
		// low while the current plane is lit
		logic oe_n;
	} hub75_bus_t;

endpackage

`default_nettype wire

//--- spi_frame_loader.sv
`timescale 1ns/1ps
`default_nettype none

module spi_frame_loader (
	input wire sysclk,
	input wire rst,
	input wire spi_sclk,
	input wire spi_ss,
	input wire spi_mosi,
	input wire ready,
	output panel_bus_pkg::fb_write_t fb_wr,
	output logic loaded
);

	// two stage synchronizers, bit 1 is the usable one
	logic [1:0] sclk_sync;
	logic [1:0] ss_sync;
	logic [1:0] mosi_sync;
	logic sclk_prev;

	logic sclk_rise;
	logic selected;
	logic word_done;
	logic accept;
	logic last_word;

	logic [$clog2(led_matrix_pkg::word_bits)-1:0] bit_cnt;
	led_matrix_pkg::pixel_word_t shift_reg;
	led_matrix_pkg::row_t wr_row;
	led_matrix_pkg::col_t wr_col;
	logic wr_en;
	// set once a bit arrives while not ready, holds until ss is released
	logic drop;

	always_ff @(posedge sysclk) begin
		if (rst) begin
			sclk_sync <= '0;
			ss_sync <= '1;
			sclk_prev <= 1'b0;
		end else begin
			sclk_sync <= {sclk_sync[0], spi_sclk};
			ss_sync <= {ss_sync[0], spi_ss};
			sclk_prev <= sclk_sync[1];
		end
	end

	assign sclk_rise = sclk_sync[1] & ~sclk_prev;
	assign selected = ~ss_sync[1];
	assign word_done = sclk_rise && selected
		&& (bit_cnt == ($bits(bit_cnt))'(led_matrix_pkg::word_bits - 1));
	assign accept = ready && !drop;
	assign last_word = (wr_row == led_matrix_pkg::row_t'(led_matrix_pkg::rows - 1))
		&& (wr_col == led_matrix_pkg::col_t'(led_matrix_pkg::columns - 1));

	// mode 0, msb first, sampled on the rising sclk edge
	always_ff @(posedge sysclk) begin
		mosi_sync <= {mosi_sync[0], spi_mosi};
		if (sclk_rise && selected) begin
			shift_reg <= {shift_reg[led_matrix_pkg::word_bits-2:0], mosi_sync[1]};
		end
	end

	always_ff @(posedge sysclk) begin
		if (rst) begin
			bit_cnt <= '0;
			wr_row <= '0;
			wr_col <= '0;
			wr_en <= 1'b0;
			loaded <= 1'b0;
			drop <= 1'b0;
		end else begin
			wr_en <= word_done && accept;
			loaded <= word_done && accept && last_word;
			if (!selected) begin
				// ss released, next frame starts at row 0 column 0
				bit_cnt <= '0;
				wr_row <= '0;
				wr_col <= '0;
				drop <= 1'b0;
			end else begin
				if (sclk_rise) begin
					if (!ready) begin
						drop <= 1'b1;
					end
					if (word_done) begin
						bit_cnt <= '0;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				// address steps once the write has gone out
				if (wr_en) begin
					wr_col <= wr_col + 1'b1;
					if (wr_col == led_matrix_pkg::col_t'(led_matrix_pkg::columns - 1)) begin
						wr_row <= wr_row + 1'b1;
					end
				end
			end
		end
	end

	// shift_reg stays put for several cycles after the last bit of a word
	assign fb_wr = '{wen: wr_en, wrow: wr_row, wcol: wr_col, wdata: shift_reg};

endmodule

`default_nettype wire

//--- frame_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_buffer (
	input wire sysclk,
	input wire front_bank,
	input wire panel_bus_pkg::fb_write_t fb_wr,
	input wire led_matrix_pkg::row_t rrow,
	input wire led_matrix_pkg::col_t rcol,
	output led_matrix_pkg::pixel_word_t rdata
);

	// bank 0 and bank 1, one word per row and column
	led_matrix_pkg::pixel_word_t mem [2][led_matrix_pkg::pixels_per_frame];

	logic [led_matrix_pkg::row_w+led_matrix_pkg::col_w-1:0] waddr;
	logic [led_matrix_pkg::row_w+led_matrix_pkg::col_w-1:0] raddr;
	logic back_bank;

	// row major, same order as the host sends
	assign waddr = {fb_wr.wrow, fb_wr.wcol};
	assign raddr = {rrow, rcol};

	// loader always fills the bank that is not on display
	assign back_bank = ~front_bank;

	always_ff @(posedge sysclk) begin
		if (fb_wr.wen) begin
			mem[back_bank][waddr] <= fb_wr.wdata;
		end
	end

	// registered read, data one cycle after the address
	always_ff @(posedge sysclk) begin
		rdata <= mem[front_bank][raddr];
	end

endmodule

`default_nettype wire

//--- frame_swap_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module frame_swap_ctrl (
	input wire sysclk,
	input wire rst,
	input wire loaded,
	input wire frame_complete,
	output logic ready,
	output logic front_bank
);

	// ready low means a full frame waits in the back bank
	always_ff @(posedge sysclk) begin
		if (rst) begin
			ready <= 1'b1;
			front_bank <= 1'b0;
		end else if (frame_complete && !ready) begin
			// flip only between frames so the panel never shows a partial load
			front_bank <= ~front_bank;
			ready <= 1'b1;
		end else if (loaded) begin
			ready <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- hub75_scan_driver.sv
`timescale 1ns/1ps
`default_nettype none

module hub75_scan_driver (
	input wire sysclk,
	input wire rst,
	input wire led_matrix_pkg::pixel_word_t rdata,
	output led_matrix_pkg::row_t rrow,
	output led_matrix_pkg::col_t rcol,
	output logic frame_complete,
	output panel_bus_pkg::hub75_bus_t panel
);

	typedef enum logic [1:0] {
		st_shift,
		st_latch,
		st_display,
		st_blank
	} scan_state_t;

	scan_state_t state;
	led_matrix_pkg::row_t row;
	led_matrix_pkg::col_t col;
	led_matrix_pkg::plane_t plane;
	led_matrix_pkg::lit_t lit_cnt;
	// 0 sets the data with oclk low, 1 raises oclk
	logic phase;
	logic [1:0] turn_cnt;

	logic last_col;
	logic last_plane;
	logic last_row;
	logic [led_matrix_pkg::segments*3-1:0] plane_bits;

	assign last_col = (col == led_matrix_pkg::col_t'(led_matrix_pkg::columns - 1));
	assign last_plane = (plane == led_matrix_pkg::plane_t'(led_matrix_pkg::bitdepth - 1));
	assign last_row = (row == led_matrix_pkg::row_t'(led_matrix_pkg::rows - 1));

	// fetch the next column while oclk is high, word is back for the next low phase
	assign rrow = row;
	assign rcol = (state == st_shift && phase) ? col + 1'b1 : col;

	// first cycle of the row turn after row 7
	assign frame_complete = (state == st_blank) && last_plane && last_row && (turn_cnt == '0);

	// bit b of each color channel, channel j sits at bits j*bitdepth and up
	always_comb begin
		for (int j = 0; j < led_matrix_pkg::segments * 3; j++) begin
			plane_bits[j] = rdata[j * led_matrix_pkg::bitdepth + plane];
		end
	end

	always_ff @(posedge sysclk) begin
		if (rst) begin
			state <= st_shift;
			row <= '0;
			col <= '0;
			plane <= '0;
			phase <= 1'b0;
			lit_cnt <= '0;
			turn_cnt <= '0;
		end else begin
			case (state)
				st_shift: begin
					phase <= ~phase;
					if (phase) begin
						if (last_col) begin
							col <= '0;
							state <= st_latch;
						end else begin
							col <= col + 1'b1;
						end
					end
				end
				st_latch: begin
					// lit for display_unit << plane cycles
					lit_cnt <= led_matrix_pkg::lit_t'((led_matrix_pkg::display_unit << plane) - 1);
					state <= st_display;
				end
				st_display: begin
					lit_cnt <= lit_cnt - 1'b1;
					if (lit_cnt == '0) begin
						state <= st_blank;
					end
				end
				st_blank: begin
					if (!last_plane) begin
						plane <= plane + 1'b1;
						state <= st_shift;
					end else begin
						// row turn, extra cycles let the new row's first word arrive
						if (turn_cnt == '0) begin
							row <= row + 1'b1;
						end
						if (turn_cnt == 2'(led_matrix_pkg::row_turn_cycles)) begin
							turn_cnt <= '0;
							plane <= '0;
							state <= st_shift;
						end else begin
							turn_cnt <= turn_cnt + 1'b1;
						end
					end
				end
				default: state <= st_shift;
			endcase
		end
	end

	// panel pins are registered, one cycle behind the state
	always_ff @(posedge sysclk) begin
		if (rst) begin
			panel.rgb <= '0;
			panel.a <= '0;
			panel.lat <= 1'b0;
			panel.oclk <= 1'b0;
			panel.oe_n <= 1'b1;
		end else begin
			panel.a <= row;
			panel.lat <= (state == st_latch);
			panel.oclk <= (state == st_shift) && phase;
			panel.oe_n <= (state != st_display);
			if (state == st_shift && !phase) begin
				panel.rgb <= plane_bits;
			end
		end
	end

endmodule

`default_nettype wire

//--- led_matrix_top.sv
`timescale 1ns/1ps
`default_nettype none

module led_matrix_top (
	input wire sysclk,
	input wire rst,
	input wire spi_sclk,
	input wire spi_ss,
	input wire spi_mosi,
	output logic spi_miso,
	output panel_bus_pkg::hub75_bus_t panel
);

	panel_bus_pkg::fb_write_t fb_wr;
	led_matrix_pkg::row_t rrow;
	led_matrix_pkg::col_t rcol;
	led_matrix_pkg::pixel_word_t rdata;

	logic loaded;
	logic ready;
	logic front_bank;
	logic frame_complete;

	// host polls this before sending the next frame
	assign spi_miso = ready;

	spi_frame_loader i_spi_frame_loader (
		.sysclk(sysclk),
		.rst(rst),
		.spi_sclk(spi_sclk),
		.spi_ss(spi_ss),
		.spi_mosi(spi_mosi),
		.ready(ready),
		.fb_wr(fb_wr),
		.loaded(loaded)
	);

	frame_buffer i_frame_buffer (
		.sysclk(sysclk),
		.front_bank(front_bank),
		.fb_wr(fb_wr),
		.rrow(rrow),
		.rcol(rcol),
		.rdata(rdata)
	);

	frame_swap_ctrl i_frame_swap_ctrl (
		.sysclk(sysclk),
		.rst(rst),
		.loaded(loaded),
		.frame_complete(frame_complete),
		.ready(ready),
		.front_bank(front_bank)
	);

	hub75_scan_driver i_hub75_scan_driver (
		.sysclk(sysclk),
		.rst(rst),
		.rdata(rdata),
		.rrow(rrow),
		.rcol(rcol),
		.frame_complete(frame_complete),
		.panel(panel)
	);

endmodule

`default_nettype wire

//--- led_matrix_properties.sv
`timescale 1ns/1ps
`default_nettype none

module led_matrix_properties (
	input wire sysclk,
	input wire rst,
	input wire panel_bus_pkg::hub75_bus_t panel
);

	int unsigned fail_count = 0;

	// latching while lit would flash half shifted data
	lat_only_dark: assert property (@(posedge sysclk) disable iff (rst)
		panel.lat |-> panel.oe_n)
	else begin
		$error("lat high while oe_n is low");
		fail_count++;
	end

	oclk_low_at_lat: assert property (@(posedge sysclk) disable iff (rst)
		panel.lat |-> !panel.oclk)
	else begin
		$error("oclk high during lat");
		fail_count++;
	end

	// row lines only move while the panel is dark
	row_steady_while_lit: assert property (@(posedge sysclk) disable iff (rst)
		!panel.oe_n |-> $stable(panel.a))
	else begin
		$error("row address changed while oe_n is low");
		fail_count++;
	end

endmodule

bind hub75_scan_driver led_matrix_properties i_led_matrix_properties (
	.sysclk(sysclk),
	.rst(rst),
	.panel(panel)
);

`default_nettype wire

//--- tb_led_matrix.sv
`timescale 1ns/1ps
`default_nettype none

module tb_led_matrix;

	localparam int words = led_matrix_pkg::pixels_per_frame;
	localparam int wbits = led_matrix_pkg::word_bits;
	localparam int columns = led_matrix_pkg::columns;
	localparam int bitdepth = led_matrix_pkg::bitdepth;
	localparam int lanes = led_matrix_pkg::segments * 3;
	localparam int half_period = 4;
	localparam int frame_lats = led_matrix_pkg::rows * bitdepth;
	// per row eight planes of shift, latch and blank, the lit time and two turn cycles
	localparam int frame_len = led_matrix_pkg::rows * (bitdepth * (2 * columns + 2)
		+ led_matrix_pkg::display_unit * 255 + 2);
	localparam int spi_len = words * wbits * 2 * half_period + 32;
	localparam int timeout_cycles = (6 * frame_len + 3 * spi_len) * 11 / 10;

	logic sysclk = 1'b0;
	logic rst = 1'b1;
	logic spi_sclk = 1'b0;
	logic spi_ss = 1'b1;
	logic spi_mosi = 1'b0;
	logic spi_miso;
	panel_bus_pkg::hub75_bus_t panel;

	// frames A, B and C
	led_matrix_pkg::pixel_word_t frames [3][words];
	logic [15:0] lfsr = 16'd11;
	int cycles = 0;
	int prop_fails;

	// monitor state, show is the frame expected on the panel
	int show = -1;
	int pending = -1;
	// rising edges of spi_miso, one per frame taken over by the display
	int handoffs = 0;
	int col_idx;
	int lat_total;
	int lit_cycles;
	int low_cycles;
	int plane_now;
	int row_now;
	logic oclk_q;
	logic lat_q;
	logic oe_n_q;
	logic miso_q;
	led_matrix_pkg::row_t a_q;
	logic [lanes-1:0] shifted [columns];

	led_matrix_top i_led_matrix_top (
		.sysclk(sysclk),
		.rst(rst),
		.spi_sclk(spi_sclk),
		.spi_ss(spi_ss),
		.spi_mosi(spi_mosi),
		.spi_miso(spi_miso),
		.panel(panel)
	);

	assign prop_fails = i_led_matrix_top.i_hub75_scan_driver.i_led_matrix_properties.fail_count;

	// 4 ns period
	always #2 sysclk = ~sysclk;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// bit b of r0 g0 b0 r1 g1 b1, color bytes from the top of the word down
	function automatic logic [lanes-1:0] plane_rgb(input led_matrix_pkg::pixel_word_t wd,
		input int b);
		logic [lanes-1:0] v;
		for (int k = 0; k < lanes; k++) begin
			v[lanes - 1 - k] = wd[wbits - bitdepth * (k + 1) + b];
		end
		return v;
	endfunction

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected) begin
			$display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			$display("Verification failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic make_frame(input int f);
		for (int w = 0; w < words; w++) begin
			for (int i = wbits - 1; i >= 0; i--) begin
				lfsr = lfsr_next(lfsr);
				frames[f][w][i] = lfsr[0];
			end
		end
	endtask

	// mode 0, msb first, ss low over the whole frame
	task automatic send_frame(input int f);
		@(posedge sysclk);
		spi_ss <= 1'b0;
		for (int w = 0; w < words; w++) begin
			for (int i = wbits - 1; i >= 0; i--) begin
				spi_mosi <= frames[f][w][i];
				repeat (half_period) @(posedge sysclk);
				spi_sclk <= 1'b1;
				repeat (half_period) @(posedge sysclk);
				spi_sclk <= 1'b0;
			end
		end
		repeat (half_period) @(posedge sysclk);
		spi_ss <= 1'b1;
		repeat (half_period) @(posedge sysclk);
	endtask

	task automatic wait_miso(input logic level, input int limit, input string what);
		int n;
		n = 0;
		@(negedge sysclk);
		while (spi_miso !== level) begin
			n++;
			if (n > limit) begin
				$display("spi_miso did not go to %0d within %0d cycles %s", level, limit, what);
				$display("Verification failed");
				$fatal(1, "ready handshake stuck");
			end
			@(negedge sysclk);
		end
	endtask

	task automatic wait_lats(input int n);
		int target;
		target = lat_total + n;
		while (lat_total < target) begin
			@(posedge sysclk);
		end
	endtask

	task automatic check_after_reset();
		@(negedge sysclk);
		check_value("panel.oe_n", panel.oe_n, 1);
		check_value("panel.lat", panel.lat, 0);
		check_value("panel.oclk", panel.oclk, 0);
		check_value("panel.a", panel.a, 0);
		check_value("spi_miso", spi_miso, 1);
	endtask

	task automatic load_and_swap();
		make_frame(0);
		pending = 0;
		send_frame(0);
		@(negedge sysclk);
		check_value("spi_miso after frame A", spi_miso, 0);
	endtask

	// frame B arrives while the loader is closed and must be ignored
	task automatic dropped_load();
		make_frame(1);
		send_frame(1);
		wait_miso(1'b1, frame_len, "after frame B");
		wait_lats(frame_lats);
		check_value("frame handoffs", handoffs, 1);
	endtask

	task automatic second_load();
		make_frame(2);
		pending = 2;
		send_frame(2);
		@(negedge sysclk);
		check_value("spi_miso after frame C", spi_miso, 0);
		wait_miso(1'b1, frame_len + 1, "after frame C");
		wait_lats(frame_lats);
		check_value("frame handoffs", handoffs, 2);
	endtask

	// panel monitor, sampled away from the active clock edge
	always @(negedge sysclk) begin
		if (rst) begin
			oclk_q = 1'b0;
			lat_q = 1'b0;
			oe_n_q = 1'b1;
			miso_q = 1'b1;
			a_q = '0;
			col_idx = 0;
			lat_total = 0;
			lit_cycles = 0;
			low_cycles = 0;
			plane_now = 0;
		end else begin
			if (panel.oclk && !oclk_q) begin
				if (col_idx < columns) begin
					shifted[col_idx] = panel.rgb;
				end
				col_idx++;
			end
			if (panel.lat && !lat_q) begin
				plane_now = lat_total % bitdepth;
				row_now = (lat_total / bitdepth) % led_matrix_pkg::rows;
				check_value("columns shifted per plane", col_idx, columns);
				check_value("panel.a at lat", panel.a, row_now);
				if (show >= 0) begin
					for (int c = 0; c < columns; c++) begin
						check_value($sformatf("panel.rgb row %0d plane %0d column %0d",
							row_now, plane_now, c), shifted[c],
							plane_rgb(frames[show][row_now * columns + c], plane_now));
					end
				end
				col_idx = 0;
				lat_total++;
			end
			if (!panel.oe_n) begin
				lit_cycles++;
			end
			if (panel.oe_n && !oe_n_q) begin
				check_value("oe_n low cycles", lit_cycles,
					led_matrix_pkg::display_unit << plane_now);
				lit_cycles = 0;
			end
			if (lat_total % bitdepth != 0) begin
				check_value("panel.a between latch pulses", panel.a, a_q);
			end
			if (!spi_miso) begin
				low_cycles++;
			end
			// new frame takes over at the start of row 0
			if (spi_miso && !miso_q) begin
				check_value("spi_miso low within a frame", low_cycles <= frame_len + 1, 1);
				check_value("latch pulses at the swap", lat_total % frame_lats, 0);
				show = pending;
				handoffs++;
				low_cycles = 0;
			end
			oclk_q = panel.oclk;
			lat_q = panel.lat;
			oe_n_q = panel.oe_n;
			miso_q = spi_miso;
			a_q = panel.a;
		end
	end

	always @(negedge sysclk) begin
		if (prop_fails != 0) begin
			$display("a panel bus assertion failed");
			$display("Verification failed");
			$fatal(1, "assertion failure");
		end
	end

	always @(posedge sysclk) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("timeout, the run did not end within %0d cycles", timeout_cycles);
			$display("Verification failed");
			$fatal(1, "timeout");
		end
	end

	initial begin
		repeat (10) @(posedge sysclk);
		rst <= 1'b0;
		check_after_reset();
		load_and_swap();
		dropped_load();
		second_load();
		@(negedge sysclk);
		if (prop_fails != 0) begin
			$display("panel bus assertions failed during the run");
			$display("Verification failed");
			$fatal(1, "assertion failure");
		end else begin
			$display("Verification passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- src.f
led_matrix_pkg.sv
panel_bus_pkg.sv
spi_frame_loader.sv
frame_buffer.sv
frame_swap_ctrl.sv
hub75_scan_driver.sv
led_matrix_top.sv
led_matrix_properties.sv
tb_led_matrix.sv
